/* project.f */
verilog/pkt_fifo_pkg.sv
verilog/pkt_regs_pkg.sv
verilog/cdc_gray_sync.sv
verilog/axis_packet_fifo.sv
verilog/fifo_apb_regs.sv
verilog/pkt_fifo_top.sv
verif/pkt_fifo_checker.sv
verif/tb_pkt_fifo.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the packet FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_pkt_fifo \
    -f project.f -o sim_pkt_fifo > build.log 2>&1 \
    && ./obj_dir/sim_pkt_fifo > sim.log 2>&1 \
    || { cat build.log; echo "Build or run did not complete"; exit 1; }

cat sim.log
grep -qx "PASS: all tests" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* verif/tb_pkt_fifo.sv */
module tb_pkt_fifo;

    localparam int DATA_W   = pkt_fifo_pkg::DATA_W_DEF;
    localparam int ADDR_W   = pkt_fifo_pkg::ADDR_W_DEF;
    localparam int DEPTH    = 2 ** ADDR_W;
    localparam int N_FRAMES = 13;
    localparam int C_LEN    = 0;
    localparam int C_DROP   = 1;
    localparam int C_START  = 2;
    localparam int C_PAUSE  = 3;

    // Each row holds length, drop flag, start byte and pause flag
    // The paused rows add up to exactly the storage depth plus one short frame
    int frame_tbl [N_FRAMES][4] = '{
        '{ 5, 0, 'h10, 0},
        '{ 3, 1, 'h20, 0},
        '{12, 0, 'h30, 0},
        '{ 1, 0, 'h40, 0},
        '{ 7, 1, 'h50, 0},
        '{ 4, 0, 'h60, 1},
        '{ 4, 0, 'h70, 1},
        '{ 4, 0, 'h80, 1},
        '{ 4, 0, 'h90, 1},
        '{ 2, 0, 'hA0, 1},
        '{ 9, 0, 'hB0, 0},
        '{11, 1, 'hC0, 0},
        '{ 3, 0, 'hD0, 0}
    };

    logic                             m_aclk = 1'b0;
    logic                             s_aclk = 1'b0;
    logic                             m_sresetn;
    logic                             s_sresetn;
    logic [DATA_W-1:0]                i_s_axis_tdata;
    logic                             i_s_axis_tlast;
    logic                             i_s_axis_tuser;
    logic                             i_s_axis_tvalid;
    logic                             o_s_axis_tready;
    logic [DATA_W-1:0]                o_m_axis_tdata;
    logic                             o_m_axis_tlast;
    logic                             o_m_axis_tvalid;
    logic                             i_m_axis_tready = 1'b0;
    logic                             i_psel;
    logic                             i_penable;
    logic                             i_pwrite;
    logic [pkt_regs_pkg::PADDR_W-1:0] i_paddr;
    logic [pkt_regs_pkg::REG_W-1:0]   i_pwdata;
    logic [pkt_regs_pkg::REG_W-1:0]   o_prdata;
    logic                             o_pready;
    int                               seed = 38490;
    int                               tb_errors = 0;
    int                               chk_errors;
    int                               chk_pending;
    int                               chk_frames;

    always #10 m_aclk = ~m_aclk;
    always #7 s_aclk = ~s_aclk;

    // Sink accepts on roughly 70 percent of the cycles
    always @(posedge m_aclk)
        i_m_axis_tready <= ($unsigned($random(seed)) % 100) < 70;

    pkt_fifo_top dut_i (.*);

    pkt_fifo_checker #(.DATA_W(DATA_W)) chk_i (
        .s_aclk     (s_aclk),
        .m_aclk     (m_aclk),
        .i_s_tdata  (i_s_axis_tdata),
        .i_s_tlast  (i_s_axis_tlast),
        .i_s_tuser  (i_s_axis_tuser),
        .i_s_tvalid (i_s_axis_tvalid),
        .i_s_tready (o_s_axis_tready),
        .i_m_tdata  (o_m_axis_tdata),
        .i_m_tlast  (o_m_axis_tlast),
        .i_m_tvalid (o_m_axis_tvalid),
        .i_m_tready (i_m_axis_tready),
        .o_errors   (chk_errors),
        .o_pending  (chk_pending),
        .o_frames   (chk_frames)
    );

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////

    function automatic int column_sum(input int col);
        int sum;
        sum = 0;
        for (int r = 0; r < N_FRAMES; r++)
            sum += frame_tbl[r][col];
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            tb_errors++;
        end
    endtask

    task automatic apb_write(input logic [pkt_regs_pkg::PADDR_W-1:0] addr,
                             input logic [31:0] data);
        @(posedge m_aclk);
        i_psel   <= 1'b1;
        i_pwrite <= 1'b1;
        i_paddr  <= addr;
        i_pwdata <= data;
        @(posedge m_aclk);
        i_penable <= 1'b1;
        @(posedge m_aclk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
    endtask

    // prdata and pready are taken mid access phase, well away from any edge
    task automatic apb_read(input logic [pkt_regs_pkg::PADDR_W-1:0] addr,
                            output logic [31:0] data);
        @(posedge m_aclk);
        i_psel   <= 1'b1;
        i_pwrite <= 1'b0;
        i_paddr  <= addr;
        @(posedge m_aclk);
        i_penable <= 1'b1;
        @(negedge m_aclk);
        data = o_prdata;
        check_value("o_pready", 32'(o_pready), 32'h1);
        @(posedge m_aclk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic read_check(input logic [pkt_regs_pkg::PADDR_W-1:0] addr,
                              input string name, input logic [31:0] exp);
        logic [31:0] rd;
        apb_read(addr, rd);
        check_value(name, rd, exp);
    endtask

    // tready is a register so its value at the falling edge is what the next edge sees
    task automatic send_frame(input int row);
        int   len;
        logic taken;
        len = frame_tbl[row][C_LEN];
        @(posedge s_aclk);
        for (int b = 0; b < len; b++) begin
            i_s_axis_tdata  <= DATA_W'(frame_tbl[row][C_START] + b);
            i_s_axis_tlast  <= (b == len - 1);
            i_s_axis_tuser  <= (b == len - 1) && (frame_tbl[row][C_DROP] != 0);
            i_s_axis_tvalid <= 1'b1;
            do begin
                @(negedge s_aclk);
                taken = o_s_axis_tready;
                @(posedge s_aclk);
            end while (!taken);
        end
        i_s_axis_tvalid <= 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge m_aclk);
        while ((chk_pending != 0 || o_m_axis_tvalid) && cycles < 2000) begin
            @(negedge m_aclk);
            cycles++;
        end
        if (cycles >= 2000) begin
            $display("Read side never drained with %0d beats still owed", chk_pending);
            tb_errors++;
        end
        // Level, empty and drop count need a few cycles to cross over
        repeat (12) @(negedge m_aclk);
    endtask

    // Fill the storage behind a paused read side, then let it all out
    task automatic run_paused(input int first, input int stop);
        logic [31:0] rd;
        int          polls;
        wait_idle();
        apb_write(pkt_regs_pkg::ADDR_CTRL, 32'(1) << pkt_regs_pkg::CTRL_PAUSE_BIT);
        fork
            begin
                for (int r = first; r < stop; r++)
                    send_frame(r);
            end
            begin
                polls = 0;
                rd = '0;
                while (rd[ADDR_W:0] != DEPTH && polls < 200) begin
                    @(negedge m_aclk);
                    check_value("o_m_axis_tvalid", 32'(o_m_axis_tvalid), 32'h0);
                    apb_read(pkt_regs_pkg::ADDR_LEVEL, rd);
                    polls++;
                end
                if (polls >= 200) begin
                    $display("Level never reached the full depth while paused");
                    tb_errors++;
                end
                @(negedge s_aclk);
                check_value("o_s_axis_tready", 32'(o_s_axis_tready), 32'h0);
                apb_write(pkt_regs_pkg::ADDR_CTRL, 32'h0);
            end
        join
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        int row;
        int first;
        m_sresetn       = 1'b0;
        s_sresetn       = 1'b0;
        i_s_axis_tdata  = '0;
        i_s_axis_tlast  = 1'b0;
        i_s_axis_tuser  = 1'b0;
        i_s_axis_tvalid = 1'b0;
        i_psel          = 1'b0;
        i_penable       = 1'b0;
        i_pwrite        = 1'b0;
        i_paddr         = '0;
        i_pwdata        = '0;
        fork
            begin
                repeat (3) @(posedge s_aclk);
                s_sresetn <= 1'b1;
            end
            begin
                repeat (2) @(posedge m_aclk);
                @(negedge m_aclk);
                check_value("o_s_axis_tready", 32'(o_s_axis_tready), 32'h0);
                check_value("o_m_axis_tvalid", 32'(o_m_axis_tvalid), 32'h0);
                @(posedge m_aclk);
                m_sresetn <= 1'b1;
            end
        join
        // Write side opens within four s_aclk cycles of the later release
        repeat (4) @(posedge s_aclk);
        @(negedge s_aclk);
        check_value("o_s_axis_tready", 32'(o_s_axis_tready), 32'h1);

        row = 0;
        while (row < N_FRAMES) begin
            if (frame_tbl[row][C_PAUSE] != 0) begin
                first = row;
                while (row < N_FRAMES && frame_tbl[row][C_PAUSE] != 0)
                    row++;
                run_paused(first, row);
            end else begin
                send_frame(row);
                row++;
            end
        end

        wait_idle();
        read_check(pkt_regs_pkg::ADDR_DROPS, "o_prdata drops", column_sum(C_DROP));
        read_check(pkt_regs_pkg::ADDR_FRAMES, "o_prdata frames", N_FRAMES - column_sum(C_DROP));
        check_value("chk_i frame count", chk_frames, N_FRAMES - column_sum(C_DROP));
        read_check(pkt_regs_pkg::ADDR_LEVEL, "o_prdata level", 32'h8000_0000);
        apb_write(pkt_regs_pkg::ADDR_CTRL, 32'(1) << pkt_regs_pkg::CTRL_CLEAR_BIT);
        read_check(pkt_regs_pkg::ADDR_FRAMES, "o_prdata frames", 32'h0);
        read_check(pkt_regs_pkg::ADDR_DROPS, "o_prdata drops", 32'h0);
        read_check(pkt_regs_pkg::ADDR_CTRL, "o_prdata ctrl", 32'h0);

        $display("Error counts: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // Budget of 200 units per beat plus a fixed margin for resets and register traffic
    initial begin
        int limit;
        limit = column_sum(C_LEN) * 200 + 5000;
        #(limit);
        $display("Watchdog expired after %0d time units before the run completed", limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* verif/pkt_fifo_checker.sv */
module pkt_fifo_checker #(
    parameter int DATA_W = 8
) (
    input  logic              s_aclk,
    input  logic              m_aclk,
    input  logic [DATA_W-1:0] i_s_tdata,
    input  logic              i_s_tlast,
    input  logic              i_s_tuser,
    input  logic              i_s_tvalid,
    input  logic              i_s_tready,
    input  logic [DATA_W-1:0] i_m_tdata,
    input  logic              i_m_tlast,
    input  logic              i_m_tvalid,
    input  logic              i_m_tready,
    output int                o_errors,
    output int                o_pending,
    output int                o_frames
);

    // Every model entry is {tdata, tlast}
    logic [DATA_W:0] open_q [$];
    logic [DATA_W:0] expect_q [$];
    logic [DATA_W:0] exp_beat;
    int              committed = 0;
    int              popped = 0;
    int              err_cnt = 0;
    int              frame_cnt = 0;

    assign o_errors  = err_cnt;
    assign o_pending = committed - popped;
    assign o_frames  = frame_cnt;

    ////////////////////////////////////////////////////////////////////
    // Write side model
    ////////////////////////////////////////////////////////////////////

    // A frame joins the expected stream only once its last beat shows tuser low
    always @(posedge s_aclk) begin
        if (i_s_tvalid && i_s_tready) begin
            open_q.push_back({i_s_tdata, i_s_tlast});
            if (i_s_tlast && !i_s_tuser) begin
                committed += open_q.size();
                foreach (open_q[i])
                    expect_q.push_back(open_q[i]);
            end
            // Dropped frames simply vanish here
            if (i_s_tlast)
                open_q.delete();
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Read side comparison
    ////////////////////////////////////////////////////////////////////

    always @(posedge m_aclk) begin
        if (i_m_tvalid && i_m_tready) begin
            if (expect_q.size() == 0) begin
                $display("Output beat 0x%h arrived with no committed frame waiting", i_m_tdata);
                err_cnt++;
            end else begin
                exp_beat = expect_q.pop_front();
                popped++;
                if (i_m_tdata !== exp_beat[DATA_W:1]) begin
                    $display("** Error: o_m_axis_tdata = 0x%h, expected 0x%h",
                             i_m_tdata, exp_beat[DATA_W:1]);
                    err_cnt++;
                end
                if (i_m_tlast !== exp_beat[0]) begin
                    $display("** Error: o_m_axis_tlast = 0x%h, expected 0x%h",
                             i_m_tlast, exp_beat[0]);
                    err_cnt++;
                end
                if (i_m_tlast)
                    frame_cnt++;
            end
        end
    end

endmodule

/* verilog/pkt_fifo_top.sv */
module pkt_fifo_top #(
    parameter int DATA_W      = pkt_fifo_pkg::DATA_W_DEF,
    parameter int ADDR_W      = pkt_fifo_pkg::ADDR_W_DEF,
    parameter int PIPE_STAGES = pkt_fifo_pkg::PIPE_STAGES_DEF
) (
    input  logic                             m_aclk,
    input  logic                             m_sresetn,
    input  logic                             s_aclk,
    input  logic                             s_sresetn,
    input  logic [DATA_W-1:0]                i_s_axis_tdata,
    input  logic                             i_s_axis_tlast,
    input  logic                             i_s_axis_tuser,
    input  logic                             i_s_axis_tvalid,
    output logic                             o_s_axis_tready,
    output logic [DATA_W-1:0]                o_m_axis_tdata,
    output logic                             o_m_axis_tlast,
    output logic                             o_m_axis_tvalid,
    input  logic                             i_m_axis_tready,
    input  logic                             i_psel,
    input  logic                             i_penable,
    input  logic                             i_pwrite,
    input  logic [pkt_regs_pkg::PADDR_W-1:0] i_paddr,
    input  logic [pkt_regs_pkg::REG_W-1:0]   i_pwdata,
    output logic [pkt_regs_pkg::REG_W-1:0]   o_prdata,
    output logic                             o_pready
);

    logic                           pause;
    logic                           frame_out;
    logic                           fifo_empty;
    logic [ADDR_W:0]                level;
    logic [pkt_fifo_pkg::CNT_W-1:0] drop_count_s;
    logic [pkt_fifo_pkg::CNT_W-1:0] drop_count_m;

    axis_packet_fifo #(
        .DATA_W      (DATA_W),
        .ADDR_W      (ADDR_W),
        .PIPE_STAGES (PIPE_STAGES)
    ) fifo_i (
        .m_aclk          (m_aclk),
        .m_sresetn       (m_sresetn),
        .s_aclk          (s_aclk),
        .s_sresetn       (s_sresetn),
        .i_s_axis_tdata  (i_s_axis_tdata),
        .i_s_axis_tlast  (i_s_axis_tlast),
        .i_s_axis_tuser  (i_s_axis_tuser),
        .i_s_axis_tvalid (i_s_axis_tvalid),
        .o_s_axis_tready (o_s_axis_tready),
        .o_m_axis_tdata  (o_m_axis_tdata),
        .o_m_axis_tlast  (o_m_axis_tlast),
        .o_m_axis_tvalid (o_m_axis_tvalid),
        .i_m_axis_tready (i_m_axis_tready),
        .i_pause         (pause),
        .o_frame_out     (frame_out),
        .o_level         (level),
        .o_empty         (fifo_empty),
        .o_drop_count    (drop_count_s)
    );

    // Drop count is built on the write clock, the registers read it on m_aclk
    cdc_gray_sync #(.WIDTH(pkt_fifo_pkg::CNT_W)) drop_sync_i (
        .i_src_clk  (s_aclk),
        .i_src_rstn (s_sresetn),
        .i_dst_clk  (m_aclk),
        .i_dst_rstn (m_sresetn),
        .i_bin      (drop_count_s),
        .o_bin      (drop_count_m)
    );

    fifo_apb_regs #(
        .ADDR_W (ADDR_W)
    ) regs_i (
        .m_aclk       (m_aclk),
        .m_sresetn    (m_sresetn),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .i_frame_out  (frame_out),
        .i_level      (level),
        .i_empty      (fifo_empty),
        .i_drop_count (drop_count_m),
        .o_pause      (pause)
    );

endmodule

/* verilog/fifo_apb_regs.sv */
module fifo_apb_regs #(
    parameter int ADDR_W = 4
) (
    input  logic                                m_aclk,
    input  logic                                m_sresetn,
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [pkt_regs_pkg::PADDR_W-1:0]    i_paddr,
    input  logic [pkt_regs_pkg::REG_W-1:0]      i_pwdata,
    output logic [pkt_regs_pkg::REG_W-1:0]      o_prdata,
    output logic                                o_pready,
    input  logic                                i_frame_out,
    input  logic [ADDR_W:0]                     i_level,
    input  logic                                i_empty,
    input  logic [pkt_fifo_pkg::CNT_W-1:0]      i_drop_count,
    output logic                                o_pause
);

    logic                           wr_en;
    logic                           ctrl_wr;
    logic                           clear;
    logic                           pause_q;
    logic [pkt_fifo_pkg::CNT_W-1:0] frame_cnt;
    logic [pkt_fifo_pkg::CNT_W-1:0] drop_ofs;

    ////////////////////////////////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////////////////////////////////

    // No wait states, every access completes in its access phase
    assign o_pready = 1'b1;

    assign wr_en   = i_psel & i_penable & i_pwrite;
    assign ctrl_wr = wr_en & (i_paddr == pkt_regs_pkg::ADDR_CTRL);
    assign clear   = ctrl_wr & i_pwdata[pkt_regs_pkg::CTRL_CLEAR_BIT];

    ////////////////////////////////////////////////////////////////////
    // Control and counters
    ////////////////////////////////////////////////////////////////////

    // Clear zeroes the frame counter outright
    // The drop count lives in the other domain, so clear only notes where it stands
    always_ff @(posedge m_aclk or negedge m_sresetn) begin
        if (!m_sresetn) begin
            pause_q   <= 1'b0;
            frame_cnt <= '0;
            drop_ofs  <= '0;
        end else begin
            if (ctrl_wr)
                pause_q <= i_pwdata[pkt_regs_pkg::CTRL_PAUSE_BIT];
            if (clear) begin
                frame_cnt <= '0;
                drop_ofs  <= i_drop_count;
            end else if (i_frame_out) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    assign o_pause = pause_q;

    ////////////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        o_prdata = '0;
        case (i_paddr)
            pkt_regs_pkg::ADDR_CTRL: begin
                // Clear bit always reads as zero
                o_prdata[pkt_regs_pkg::CTRL_PAUSE_BIT] = pause_q;
            end
            pkt_regs_pkg::ADDR_LEVEL: begin
                o_prdata[ADDR_W:0] = i_level;
                // Empty flag rides in the top bit
                o_prdata[pkt_regs_pkg::REG_W-1] = i_empty;
            end
            pkt_regs_pkg::ADDR_FRAMES: begin
                o_prdata[pkt_fifo_pkg::CNT_W-1:0] = frame_cnt;
            end
            pkt_regs_pkg::ADDR_DROPS: begin
                // Wraps cleanly since both sides share the counter width
                o_prdata[pkt_fifo_pkg::CNT_W-1:0] = i_drop_count - drop_ofs;
            end
            default: begin
                o_prdata = '0;
            end
        endcase
    end

    // An access phase is only legal after a setup phase of the same transfer
    a_penable_psel : assert property (@(posedge m_aclk) disable iff (!m_sresetn)
        i_penable |-> (i_psel && $past(i_psel)))
        else $error("fifo_apb_regs: penable without a preceding psel");

endmodule

/* verilog/axis_packet_fifo.sv */
module axis_packet_fifo #(
    parameter int DATA_W      = 8,
    parameter int ADDR_W      = 4,
    parameter int PIPE_STAGES = 2
) (
    input  logic                           m_aclk,
    input  logic                           m_sresetn,
    input  logic                           s_aclk,
    input  logic                           s_sresetn,
    input  logic [DATA_W-1:0]              i_s_axis_tdata,
    input  logic                           i_s_axis_tlast,
    input  logic                           i_s_axis_tuser,
    input  logic                           i_s_axis_tvalid,
    output logic                           o_s_axis_tready,
    output logic [DATA_W-1:0]              o_m_axis_tdata,
    output logic                           o_m_axis_tlast,
    output logic                           o_m_axis_tvalid,
    input  logic                           i_m_axis_tready,
    input  logic                           i_pause,
    output logic                           o_frame_out,
    output logic [ADDR_W:0]                o_level,
    output logic                           o_empty,
    output logic [pkt_fifo_pkg::CNT_W-1:0] o_drop_count
);

    localparam int WORD_W   = pkt_fifo_pkg::word_w(DATA_W);
    localparam int DEPTH    = 2 ** ADDR_W;
    localparam int DATA_LSB = pkt_fifo_pkg::LAST_BIT + 1;

    // Shared storage, written from s_aclk and read from m_aclk
    logic [WORD_W-1:0] mem [DEPTH];

    ////////////////////////////////////////////////////////////////////
    // Reset bridging
    ////////////////////////////////////////////////////////////////////

    // Either reset pulls both domains down at once, release follows each clock
    logic       both_rstn;
    logic [1:0] s_rst_sync;
    logic [1:0] m_rst_sync;
    logic       s_rstn;
    logic       m_rstn;

    assign both_rstn = s_sresetn & m_sresetn;

    always_ff @(posedge s_aclk or negedge both_rstn) begin
        if (!both_rstn) begin
            s_rst_sync <= '0;
        end else begin
            s_rst_sync <= {s_rst_sync[0], 1'b1};
        end
    end

    always_ff @(posedge m_aclk or negedge both_rstn) begin
        if (!both_rstn) begin
            m_rst_sync <= '0;
        end else begin
            m_rst_sync <= {m_rst_sync[0], 1'b1};
        end
    end

    assign s_rstn = s_rst_sync[1];
    assign m_rstn = m_rst_sync[1];

    ////////////////////////////////////////////////////////////////////
    // Write side, s_aclk
    ////////////////////////////////////////////////////////////////////

    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   wr_ptr_next;
    logic [ADDR_W:0]   wr_commit;
    logic [ADDR_W:0]   wr_pub;
    logic [ADDR_W:0]   rd_ptr_s;
    logic              wr_accept;
    logic              last_good;
    logic              last_bad;
    logic              full;
    logic              full_next;
    logic              s_ready_q;
    logic [WORD_W-1:0] wr_word;

    assign wr_accept = i_s_axis_tvalid & s_ready_q;
    assign last_good = wr_accept & i_s_axis_tlast & ~i_s_axis_tuser;
    assign last_bad  = wr_accept & i_s_axis_tlast & i_s_axis_tuser;

    // A bad last beat throws the whole frame away by rewinding to the boundary
    always_comb begin
        if (last_bad)
            wr_ptr_next = wr_commit;
        else if (wr_accept)
            wr_ptr_next = wr_ptr + 1'b1;
        else
            wr_ptr_next = wr_ptr;
    end

    // Full when the pointers match in address but differ in the wrap bit
    assign full = (wr_ptr[ADDR_W] != rd_ptr_s[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr_s[ADDR_W-1:0]);
    assign full_next = (wr_ptr_next[ADDR_W] != rd_ptr_s[ADDR_W]) &&
                       (wr_ptr_next[ADDR_W-1:0] == rd_ptr_s[ADDR_W-1:0]);

    // wr_pub walks one step at a time towards wr_commit
    // so that the Gray crossing only ever sees single steps
    always_ff @(posedge s_aclk or negedge s_rstn) begin
        if (!s_rstn) begin
            wr_ptr       <= '0;
            wr_commit    <= '0;
            wr_pub       <= '0;
            s_ready_q    <= 1'b0;
            o_drop_count <= '0;
        end else begin
            wr_ptr    <= wr_ptr_next;
            // Read pointer only moves away from full, so this stays safe
            s_ready_q <= ~full_next;
            if (last_good)
                wr_commit <= wr_ptr + 1'b1;
            if (last_bad)
                o_drop_count <= o_drop_count + 1'b1;
            if (wr_pub != wr_commit)
                wr_pub <= wr_pub + 1'b1;
        end
    end

    always_comb begin
        wr_word = '0;
        wr_word[pkt_fifo_pkg::LAST_BIT] = i_s_axis_tlast;
        wr_word[DATA_LSB +: DATA_W] = i_s_axis_tdata;
    end

    always_ff @(posedge s_aclk) begin
        if (wr_accept)
            mem[wr_ptr[ADDR_W-1:0]] <= wr_word;
    end

    assign o_s_axis_tready = s_ready_q;

    ////////////////////////////////////////////////////////////////////
    // Pointer crossings
    ////////////////////////////////////////////////////////////////////

    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] wr_ptr_m;

    cdc_gray_sync #(.WIDTH(ADDR_W + 1)) wr_sync_i (
        .i_src_clk  (s_aclk),
        .i_src_rstn (s_rstn),
        .i_dst_clk  (m_aclk),
        .i_dst_rstn (m_rstn),
        .i_bin      (wr_pub),
        .o_bin      (wr_ptr_m)
    );

    cdc_gray_sync #(.WIDTH(ADDR_W + 1)) rd_sync_i (
        .i_src_clk  (m_aclk),
        .i_src_rstn (m_rstn),
        .i_dst_clk  (s_aclk),
        .i_dst_rstn (s_rstn),
        .i_bin      (rd_ptr),
        .o_bin      (rd_ptr_s)
    );

    ////////////////////////////////////////////////////////////////////
    // Read side and output pipeline, m_aclk
    ////////////////////////////////////////////////////////////////////

    logic [PIPE_STAGES:0] pipe_vld;
    logic [WORD_W-1:0]    pipe_word [PIPE_STAGES+1];
    logic                 store_empty;
    logic                 advance;
    logic                 rd_en;

    assign store_empty = (rd_ptr == wr_ptr_m);
    // The whole pipe shifts when the head is free or being taken
    assign advance = ~pipe_vld[PIPE_STAGES] | i_m_axis_tready;
    // Pause only stops new storage reads, beats in flight keep moving
    assign rd_en = advance & ~store_empty & ~i_pause;

    always_ff @(posedge m_aclk or negedge m_rstn) begin
        if (!m_rstn) begin
            rd_ptr   <= '0;
            pipe_vld <= '0;
        end else if (advance) begin
            for (int i = PIPE_STAGES; i > 0; i--) begin
                pipe_vld[i] <= pipe_vld[i-1];
            end
            pipe_vld[0] <= rd_en;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Stage 0 is the storage read register
    always_ff @(posedge m_aclk) begin
        if (advance) begin
            pipe_word[0] <= mem[rd_ptr[ADDR_W-1:0]];
            for (int i = 1; i <= PIPE_STAGES; i++) begin
                pipe_word[i] <= pipe_word[i-1];
            end
        end
    end

    assign o_m_axis_tvalid = pipe_vld[PIPE_STAGES];
    assign o_m_axis_tdata  = pipe_word[PIPE_STAGES][DATA_LSB +: DATA_W];
    assign o_m_axis_tlast  = pipe_word[PIPE_STAGES][pkt_fifo_pkg::LAST_BIT];
    assign o_frame_out     = o_m_axis_tvalid & i_m_axis_tready & o_m_axis_tlast;

    // Committed words still in storage, the pipe is not counted
    assign o_level = wr_ptr_m - rd_ptr;
    assign o_empty = store_empty & ~(|pipe_vld);

    a_no_write_full : assert property (@(posedge s_aclk) disable iff (!s_rstn)
        wr_accept |-> !full)
        else $error("axis_packet_fifo: write accepted while full");

    // A read past the published pointer would wrap the level above the depth
    a_no_read_empty : assert property (@(posedge m_aclk) disable iff (!m_rstn)
        o_level <= DEPTH)
        else $error("axis_packet_fifo: read side passed the committed pointer");

endmodule

/* verilog/cdc_gray_sync.sv */
module cdc_gray_sync #(
    parameter int WIDTH = 5
) (
    input  logic             i_src_clk,
    input  logic             i_src_rstn,
    input  logic             i_dst_clk,
    input  logic             i_dst_rstn,
    input  logic [WIDTH-1:0] i_bin,
    output logic [WIDTH-1:0] o_bin
);

    logic [WIDTH-1:0] src_gray;
    logic [WIDTH-1:0] meta_gray;
    logic [WIDTH-1:0] sync_gray;

    // Gray encode in the source domain so only one bit moves per step
    always_ff @(posedge i_src_clk or negedge i_src_rstn) begin
        if (!i_src_rstn) begin
            src_gray <= '0;
        end else begin
            src_gray <= i_bin ^ (i_bin >> 1);
        end
    end

    // Two flop synchronizer in the destination domain
    always_ff @(posedge i_dst_clk or negedge i_dst_rstn) begin
        if (!i_dst_rstn) begin
            meta_gray <= '0;
            sync_gray <= '0;
        end else begin
            meta_gray <= src_gray;
            sync_gray <= meta_gray;
        end
    end

    // Gray to binary, each bit is the XOR of all Gray bits at or above it
    always_comb begin
        o_bin[WIDTH-1] = sync_gray[WIDTH-1];
        for (int i = WIDTH - 2; i >= 0; i--) begin
            o_bin[i] = o_bin[i+1] ^ sync_gray[i];
        end
    end

    // The source value must step by one so the crossing never sees a torn code
    a_gray_one_bit : assert property (@(posedge i_src_clk)
        disable iff (!i_src_rstn || !i_dst_rstn)
        $countones(src_gray ^ $past(src_gray)) <= 1)
        else $error("cdc_gray_sync: source Gray code moved more than one bit");

endmodule

/* verilog/pkt_regs_pkg.sv */
package pkt_regs_pkg;

    ////////////////////////////////////////////////////////////////////
    // APB bus geometry
    ////////////////////////////////////////////////////////////////////

    // Data width of prdata and pwdata
    localparam int REG_W = 32;

    // Width of paddr
    localparam int PADDR_W = 8;

    ////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////

    localparam logic [PADDR_W-1:0] ADDR_CTRL   = 8'h00;
    localparam logic [PADDR_W-1:0] ADDR_LEVEL  = 8'h04;
    localparam logic [PADDR_W-1:0] ADDR_FRAMES = 8'h08;
    localparam logic [PADDR_W-1:0] ADDR_DROPS  = 8'h0C;

    // Control bits, the clear bit reads back as zero
    localparam int CTRL_PAUSE_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;

endpackage

/* verilog/pkt_fifo_pkg.sv */
package pkt_fifo_pkg;

    ////////////////////////////////////////////////////////////////////
    // Stream widths and FIFO geometry defaults
    ////////////////////////////////////////////////////////////////////

    // Width of tdata on both stream sides
    localparam int DATA_W_DEF = 8;

    // FIFO address width, so the storage holds 2**ADDR_W_DEF words
    localparam int ADDR_W_DEF = 4;

    // Output pipeline stages that follow the storage read register
    localparam int PIPE_STAGES_DEF = 2;

    // Width of the frame statistics counters
    localparam int CNT_W = 16;

    ////////////////////////////////////////////////////////////////////
    // Layout of one stored word
    ////////////////////////////////////////////////////////////////////

    // tlast sits at this bit and tdata fills the bits above it
    localparam int LAST_BIT = 0;

    // Stored word width for a given tdata width
    function automatic int word_w(input int data_w);
        return data_w + LAST_BIT + 1;
    endfunction

endpackage
